// File: esp32_osd.f
verilog/osd_pkg.sv
verilog/spi_byte_rx.sv
verilog/osd_cmd_decoder.sv
verilog/osd_char_buffer.sv
verilog/osd_renderer.sv
verilog/osd_mixer.sv
verilog/esp32_osd.sv
verif/tb_esp32_osd.sv

// File: run_sim.sh
#!/bin/sh
# Build the esp32_osd testbench with Verilator, run it and look for the pass line
set -e
cd "$(dirname "$0")"

verilator --binary --timescale 1ns/1ps --top-module tb_esp32_osd \
    -f esp32_osd.f -o sim_tb_esp32_osd

out=$(./obj_dir/sim_tb_esp32_osd)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'Done: no errors'; then
    exit 0
fi
exit 1

// File: verif/tb_esp32_osd.sv
// ========================================
// ESP32 OSD testbench
// Sends SPI command frames from a table,
// probes video pixels and compares them
// with a reference model of the OSD
// ========================================

module tb_esp32_osd;

    timeunit 1ns;
    timeprecision 1ps;

    import osd_pkg::*;

    logic       clk_video;
    logic       rst_n;
    logic       spi_clk;
    logic       spi_mosi;
    logic       spi_cs_n;
    pixel_t     video_in;
    logic       de_in;
    logic       hs_in;
    logic       vs_in;
    coord_t     pixel_x;
    coord_t     pixel_y;
    pixel_t     video_out;
    logic       de_out;
    logic       hs_out;
    logic       vs_out;
    logic [31:0] status;
    logic [15:0] joystick_0;
    logic [15:0] joystick_1;

    esp32_osd dut_i (
        .clk_video (clk_video),
        .rst_n     (rst_n),
        .spi_clk   (spi_clk),
        .spi_mosi  (spi_mosi),
        .spi_cs_n  (spi_cs_n),
        .video_in  (video_in),
        .de_in     (de_in),
        .hs_in     (hs_in),
        .vs_in     (vs_in),
        .pixel_x   (pixel_x),
        .pixel_y   (pixel_y),
        .video_out (video_out),
        .de_out    (de_out),
        .hs_out    (hs_out),
        .vs_out    (vs_out),
        .status    (status),
        .joystick_0(joystick_0),
        .joystick_1(joystick_1)
    );

    // ========================================
    // Stimulus table and reference model
    // ========================================
    // One entry per test, row < 0 means no video probes
    string       t_name[$];
    bit          t_cmd[$];
    logic [7:0]  t_op[$];
    // Joystick or status word, or step and base nibbles of a line pattern
    logic [31:0] t_word[$];
    // Payload bytes sent before chip select rises
    int          t_sent[$];
    int          t_row[$];
    int          t_col[$];

    logic [7:0]  frame_q[$];
    logic [7:0]  grid [OSD_ROWS][OSD_COLS];
    logic        model_enable;
    logic [15:0] model_joy0;
    logic [15:0] model_joy1;
    logic [31:0] model_status;

    integer      seed;
    int          error_count;
    int          fail_tests;
    bit          table_ready;
    longint      limit_ns;

    // 100 ns clock
    initial begin
        clk_video = 1'b0;
        forever #50 clk_video = ~clk_video;
    end

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk_video);
    endtask

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s mismatch, got %0h expected %0h",
                     $time, what, got, exp);
        end
    endtask

    task automatic add_test(input string name, input bit has_cmd, input logic [7:0] op,
                            input logic [31:0] word, input int n_sent,
                            input int row, input int col);
        t_name.push_back(name);
        t_cmd.push_back(has_cmd);
        t_op.push_back(op);
        t_word.push_back(word);
        t_sent.push_back(n_sent);
        t_row.push_back(row);
        t_col.push_back(col);
    endtask

    // Opcode then payload, line characters follow col*step+base
    task automatic build_frame(input logic [7:0] op, input logic [31:0] word,
                               input int n_sent);
        int v;
        frame_q = {};
        frame_q.push_back(op);
        for (int i = 0; i < n_sent; i++) begin
            if (op[7:4] == 4'h2) begin
                v = i * int'(word[7:4]) + int'(word[3:0]);
                frame_q.push_back(8'(v & 15));
            end else begin
                frame_q.push_back(word[8*i +: 8]);
            end
        end
    endtask

    // Mode 0, MSB first, 4 cycles per half period
    task automatic shift_spi_byte(input logic [7:0] data);
        for (int b = 7; b >= 0; b--) begin
            spi_mosi <= data[b];
            wait_cycles(4);
            spi_clk <= 1'b1;
            wait_cycles(4);
            spi_clk <= 1'b0;
        end
    endtask

    task automatic send_frame();
        spi_cs_n <= 1'b0;
        wait_cycles(4);
        foreach (frame_q[k])
            shift_spi_byte(frame_q[k]);
        wait_cycles(4);
        spi_cs_n <= 1'b1;
        // Chip select synchronizer plus decoder update
        wait_cycles(8);
    endtask

    // Apply the bytes actually sent, low byte first for words
    task automatic update_model();
        logic [7:0] op;
        op = frame_q[0];
        for (int i = 1; i < frame_q.size(); i++) begin
            if (op >= 8'h20 && op <= 8'h2F)
                grid[op[3:0]][i-1] = frame_q[i];
            else if (op == 8'h02 && i <= 2)
                model_joy0[8*(i-1) +: 8] = frame_q[i];
            else if (op == 8'h03 && i <= 2)
                model_joy1[8*(i-1) +: 8] = frame_q[i];
            else if (op == 8'h1E && i <= 4)
                model_status[8*(i-1) +: 8] = frame_q[i];
        end
        if (op == 8'h41)
            model_enable = 1'b1;
        else if (op == 8'h40)
            model_enable = 1'b0;
    endtask

    // Mosaic quadrants, bit 0 TL, 1 TR, 2 BL, 3 BR
    function automatic pixel_t predict_pixel(input coord_t x, input coord_t y,
                                             input pixel_t vid);
        int         rx;
        int         ry;
        int         q;
        logic [7:0] code;
        rx = int'(x) - int'(OSD_X_OFFSET);
        ry = int'(y) - int'(OSD_Y_OFFSET);
        if (!model_enable || rx < 0 || ry < 0 ||
            rx >= OSD_COLS * CELL_PX || ry >= OSD_ROWS * CELL_PX)
            return vid;
        code = grid[ry / CELL_PX][rx / CELL_PX];
        q = ((ry % CELL_PX) >= CELL_PX / 2 ? 2 : 0) + ((rx % CELL_PX) >= CELL_PX / 2 ? 1 : 0);
        if (code[q])
            return OSD_FG_RGB;
        return {vid[23:16] >> 1, vid[15:8] >> 1, vid[7:0] >> 1};
    endfunction

    task automatic drive_idle();
        pixel_x  <= '0;
        pixel_y  <= '0;
        video_in <= '0;
        de_in    <= 1'b0;
        hs_in    <= 1'b1;
        vs_in    <= 1'b1;
    endtask

    // One pixel in, idle after it, result three edges later
    task automatic probe_pixel(input coord_t x, input coord_t y, input string where);
        logic [31:0] rnd;
        pixel_t      exp_vid;
        rnd     = $random(seed);
        exp_vid = predict_pixel(x, y, rnd[23:0]);
        pixel_x  <= x;
        pixel_y  <= y;
        video_in <= rnd[23:0];
        de_in    <= rnd[24];
        hs_in    <= rnd[25];
        vs_in    <= rnd[26];
        @(posedge clk_video);
        drive_idle();
        wait_cycles(2);
        @(negedge clk_video);
        check_value($sformatf("video_out %s (%0d,%0d)", where, x, y),
                    32'(video_out), 32'(exp_vid));
        check_value($sformatf("de_out %s", where), 32'(de_out), 32'(rnd[24]));
        check_value($sformatf("hs_out %s", where), 32'(hs_out), 32'(rnd[25]));
        check_value($sformatf("vs_out %s", where), 32'(vs_out), 32'(rnd[26]));
        @(posedge clk_video);
    endtask

    // Four quadrant corners of a cell, then three points just outside the window
    task automatic probe_cell(input int row, input int col);
        int x0;
        int y0;
        x0 = int'(OSD_X_OFFSET) + col * CELL_PX;
        y0 = int'(OSD_Y_OFFSET) + row * CELL_PX;
        for (int q = 0; q < 4; q++)
            probe_pixel(coord_t'(x0 + (q % 2 == 1 ? 7 : 0)),
                        coord_t'(y0 + (q >= 2 ? 4 : 3)), $sformatf("quadrant %0d", q));
        probe_pixel(coord_t'(int'(OSD_X_OFFSET) - 1), coord_t'(y0 + 2), "left of window");
        probe_pixel(coord_t'(int'(OSD_X_OFFSET) + OSD_COLS * CELL_PX), coord_t'(y0 + 2),
                    "right of window");
        probe_pixel(coord_t'(x0 + 1), coord_t'(int'(OSD_Y_OFFSET) + OSD_ROWS * CELL_PX),
                    "below window");
    endtask

    task automatic check_control_words();
        @(negedge clk_video);
        check_value("status", status, model_status);
        check_value("joystick_0", 32'(joystick_0), 32'(model_joy0));
        check_value("joystick_1", 32'(joystick_1), 32'(model_joy1));
        @(posedge clk_video);
    endtask

    task automatic report_test(input int idx, input string name, input int errs_before);
        if (error_count == errs_before) begin
            $display("test %0d %s: pass", idx, name);
        end else begin
            fail_tests++;
            $display("test %0d %s: FAIL, %0d errors", idx, name, error_count - errs_before);
        end
    endtask

    // ========================================
    // Main sequence
    // ========================================
    initial begin
        int     errs_before;
        longint bytes;
        seed         = 6381;
        error_count  = 0;
        fail_tests   = 0;
        table_ready  = 1'b0;
        rst_n        = 1'b0;
        spi_clk      = 1'b0;
        spi_mosi     = 1'b0;
        spi_cs_n     = 1'b1;
        video_in     = '0;
        de_in        = 1'b0;
        hs_in        = 1'b1;
        vs_in        = 1'b1;
        pixel_x      = '0;
        pixel_y      = '0;
        model_enable = 1'b0;
        model_joy0   = '0;
        model_joy1   = '0;
        model_status = '0;

        add_test("joystick 0 load", 1, 8'h02, 32'h0000_1234, 2, -1, 0);
        add_test("joystick 1 load", 1, 8'h03, 32'h0000_BEEF, 2, -1, 0);
        add_test("status load", 1, 8'h1E, 32'hDEAD_BEEF, 4, -1, 0);
        add_test("joystick 0 abort", 1, 8'h02, 32'h0000_55AB, 1, -1, 0);
        add_test("passthrough disabled", 0, 8'h00, 32'h0, 0, 5, 10);
        add_test("write line 0", 1, 8'h20, 32'h10, 32, -1, 0);
        add_test("write line 5", 1, 8'h25, 32'h15, 32, -1, 0);
        add_test("write line 15", 1, 8'h2F, 32'h1F, 32, -1, 0);
        add_test("enable, cell 0/3", 1, 8'h41, 32'h0, 0, 0, 3);
        add_test("cell 5/10", 0, 8'h00, 32'h0, 0, 5, 10);
        add_test("cell 15/31", 0, 8'h00, 32'h0, 0, 15, 31);
        add_test("cell 5/11", 0, 8'h00, 32'h0, 0, 5, 11);
        add_test("disable", 1, 8'h40, 32'h0, 0, 0, 3);
        add_test("unknown opcode", 1, 8'h37, 32'h0, 0, 5, 10);
        add_test("enable again", 1, 8'h41, 32'h0, 0, 5, 10);
        add_test("rewrite line 5", 1, 8'h25, 32'h37, 32, 5, 10);
        add_test("line 0 unchanged", 0, 8'h00, 32'h0, 0, 0, 3);

        // SPI time per byte plus a per-test allowance for probes
        bytes = 0;
        foreach (t_sent[i])
            bytes += 1 + t_sent[i];
        limit_ns = (bytes * 64 + longint'(t_name.size()) * 300 + 500) * 100;
        table_ready = 1'b1;

        // Reset held for 10 edges, outputs checked while it is held
        wait_cycles(9);
        @(negedge clk_video);
        check_value("de_out in reset", 32'(de_out), 32'd0);
        check_value("hs_out in reset", 32'(hs_out), 32'd1);
        check_value("vs_out in reset", 32'(vs_out), 32'd1);
        check_value("video_out in reset", 32'(video_out), 32'd0);
        check_value("status in reset", status, 32'd0);
        check_value("joystick_0 in reset", 32'(joystick_0), 32'd0);
        check_value("joystick_1 in reset", 32'(joystick_1), 32'd0);
        report_test(0, "reset state", 0);
        @(posedge clk_video);
        rst_n <= 1'b1;
        wait_cycles(4);

        for (int i = 0; i < t_name.size(); i++) begin
            errs_before = error_count;
            if (t_cmd[i]) begin
                build_frame(t_op[i], t_word[i], t_sent[i]);
                send_frame();
                update_model();
            end
            check_control_words();
            if (t_row[i] >= 0)
                probe_cell(t_row[i], t_col[i]);
            report_test(i + 1, t_name[i], errs_before);
        end

        $display("%0d tests run, %0d failed, %0d errors",
                 t_name.size() + 1, fail_tests, error_count);
        if (error_count == 0)
            $display("Done: no errors");
        else
            $display("Done: errors found");
        $finish;
    end

    // Watchdog
    initial begin
        wait (table_ready);
        #(limit_ns);
        $display("watchdog: tests did not complete within %0d ns, run timed out", limit_ns);
        $display("Done: errors found");
        $finish;
    end

endmodule

// File: verilog/esp32_osd.sv
// ========================================
// ESP32 OSD top level
// SPI receiver, command decoder, character
// buffer, renderer and video mixer
// ========================================

module esp32_osd (
    input  logic            clk_video,
    input  logic            rst_n,
    // SPI from the microcontroller
    input  logic            spi_clk,
    input  logic            spi_mosi,
    input  logic            spi_cs_n,
    // Video in
    input  osd_pkg::pixel_t video_in,
    input  logic            de_in,
    input  logic            hs_in,
    input  logic            vs_in,
    input  osd_pkg::coord_t pixel_x,
    input  osd_pkg::coord_t pixel_y,
    // Video out, three cycles behind
    output osd_pkg::pixel_t video_out,
    output logic            de_out,
    output logic            hs_out,
    output logic            vs_out,
    // Control words
    output logic [31:0]     status,
    output logic [15:0]     joystick_0,
    output logic [15:0]     joystick_1
);

    import osd_pkg::*;

    logic [7:0] rx_data;
    logic       rx_valid;
    logic       frame_active;
    buf_addr_t  wr_addr;
    logic [7:0] wr_data;
    logic       wr_en;
    buf_addr_t  rd_addr;
    logic [7:0] rd_data;
    logic       osd_enable;
    logic       osd_visible;
    logic       osd_pixel;

    spi_byte_rx u_spi_rx (
        .clk_video    (clk_video),
        .rst_n        (rst_n),
        .spi_clk      (spi_clk),
        .spi_mosi     (spi_mosi),
        .spi_cs_n     (spi_cs_n),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .frame_active (frame_active)
    );

    osd_cmd_decoder u_decoder (
        .clk_video    (clk_video),
        .rst_n        (rst_n),
        .rx_data      (rx_data),
        .rx_valid     (rx_valid),
        .frame_active (frame_active),
        .wr_addr      (wr_addr),
        .wr_data      (wr_data),
        .wr_en        (wr_en),
        .osd_enable   (osd_enable),
        .status       (status),
        .joystick_0   (joystick_0),
        .joystick_1   (joystick_1)
    );

    osd_char_buffer u_buffer (
        .clk_video (clk_video),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .wr_en     (wr_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data)
    );

    osd_renderer u_renderer (
        .clk_video   (clk_video),
        .rst_n       (rst_n),
        .pixel_x     (pixel_x),
        .pixel_y     (pixel_y),
        .osd_enable  (osd_enable),
        .rd_addr     (rd_addr),
        .rd_data     (rd_data),
        .osd_visible (osd_visible),
        .osd_pixel   (osd_pixel)
    );

    osd_mixer u_mixer (
        .clk_video   (clk_video),
        .rst_n       (rst_n),
        .video_in    (video_in),
        .de_in       (de_in),
        .hs_in       (hs_in),
        .vs_in       (vs_in),
        .osd_visible (osd_visible),
        .osd_pixel   (osd_pixel),
        .video_out   (video_out),
        .de_out      (de_out),
        .hs_out      (hs_out),
        .vs_out      (vs_out)
    );

endmodule

// File: verilog/osd_mixer.sv
// ========================================
// OSD video mixer
// Delays video and sync to meet the
// renderer, then overlays the OSD with a
// dimmed background under the window
// ========================================

module osd_mixer (
    input  logic            clk_video,
    input  logic            rst_n,
    input  osd_pkg::pixel_t video_in,
    input  logic            de_in,
    input  logic            hs_in,
    input  logic            vs_in,
    input  logic            osd_visible,
    input  logic            osd_pixel,
    output osd_pkg::pixel_t video_out,
    output logic            de_out,
    output logic            hs_out,
    output logic            vs_out
);

    import osd_pkg::*;

    pixel_t     video_d1;
    pixel_t     video_d2;
    pixel_t     video_dim;
    logic [1:0] de_d;
    logic [1:0] hs_d;
    logic [1:0] vs_d;

    // Two delay stages for the pixel data
    always_ff @(posedge clk_video) begin
        video_d1 <= video_in;
        video_d2 <= video_d1;
    end

    // Each channel halved
    assign video_dim = {1'b0, video_d2[23:17], 1'b0, video_d2[15:9], 1'b0, video_d2[7:1]};

    // ========================================
    // Sync delay and output stage
    // ========================================
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            de_d      <= 2'b00;
            hs_d      <= 2'b11;
            vs_d      <= 2'b11;
            de_out    <= 1'b0;
            hs_out    <= 1'b1;
            vs_out    <= 1'b1;
            video_out <= '0;
        end else begin
            de_d   <= {de_d[0], de_in};
            hs_d   <= {hs_d[0], hs_in};
            vs_d   <= {vs_d[0], vs_in};
            de_out <= de_d[1];
            hs_out <= hs_d[1];
            vs_out <= vs_d[1];
            // Foreground, dimmed window, or plain video
            if (osd_visible && osd_pixel)
                video_out <= OSD_FG_RGB;
            else if (osd_visible)
                video_out <= video_dim;
            else
                video_out <= video_d2;
        end
    end

endmodule

// File: verilog/osd_renderer.sv
// ========================================
// OSD renderer
// Maps pixel coordinates to a character
// cell, fetches its code and lights the
// mosaic quadrant that the pixel falls in
// ========================================

module osd_renderer (
    input  logic               clk_video,
    input  logic               rst_n,
    input  osd_pkg::coord_t    pixel_x,
    input  osd_pkg::coord_t    pixel_y,
    input  logic               osd_enable,
    output osd_pkg::buf_addr_t rd_addr,
    input  logic [7:0]         rd_data,
    output logic               osd_visible,
    output logic               osd_pixel
);

    import osd_pkg::*;

    // Window size in pixels
    localparam int WIN_W = OSD_COLS * CELL_PX;
    localparam int WIN_H = OSD_ROWS * CELL_PX;

    coord_t     rel_x;
    coord_t     rel_y;
    logic       inside_x;
    logic       inside_y;
    logic       in_window;
    // Stage 1 registers
    logic       win_d1;
    logic [1:0] quad_d1;

    // ========================================
    // Stage 1, window test and cell address
    // ========================================
    assign rel_x = pixel_x - OSD_X_OFFSET;
    assign rel_y = pixel_y - OSD_Y_OFFSET;

    // Lower bound by coordinate, upper bound by offset distance
    assign inside_x  = (pixel_x >= OSD_X_OFFSET) && (rel_x < COORD_W'(WIN_W));
    assign inside_y  = (pixel_y >= OSD_Y_OFFSET) && (rel_y < COORD_W'(WIN_H));
    assign in_window = inside_x && inside_y && osd_enable;

    // Row from rel_y[6:3], column from rel_x[7:3]
    // Buffer registers the read alongside stage 1
    assign rd_addr = {rel_y[6:3], rel_x[7:3]};

    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            win_d1  <= 1'b0;
            quad_d1 <= 2'd0;
        end else begin
            win_d1  <= in_window;
            // Bit 0 TL, 1 TR, 2 BL, 3 BR
            quad_d1 <= {rel_y[2], rel_x[2]};
        end
    end

    // ========================================
    // Stage 2, mosaic bit select
    // ========================================
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            osd_visible <= 1'b0;
            osd_pixel   <= 1'b0;
        end else begin
            osd_visible <= win_d1;
            // Forced low outside the window
            osd_pixel   <= win_d1 & rd_data[quad_d1];
        end
    end

endmodule

// File: verilog/osd_char_buffer.sv
// ========================================
// OSD character buffer
// 16 lines of 32 character codes, one
// write port and one registered read port
// ========================================

module osd_char_buffer (
    input  logic               clk_video,
    input  osd_pkg::buf_addr_t wr_addr,
    input  logic [7:0]         wr_data,
    input  logic               wr_en,
    input  osd_pkg::buf_addr_t rd_addr,
    output logic [7:0]         rd_data
);

    import osd_pkg::*;

    logic [7:0] mem [0:OSD_COLS*OSD_ROWS-1];

    // Write port, fed by the command decoder
    always_ff @(posedge clk_video) begin
        if (wr_en)
            mem[wr_addr] <= wr_data;
    end

    // Read port, one cycle of latency
    always_ff @(posedge clk_video) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: verilog/osd_cmd_decoder.sv
// ========================================
// OSD command decoder
// Interprets MiSTer-style commands from the
// SPI byte stream, writes text lines to the
// character buffer and holds the enable,
// joystick and status registers
// ========================================

module osd_cmd_decoder (
    input  logic               clk_video,
    input  logic               rst_n,
    input  logic [7:0]         rx_data,
    input  logic               rx_valid,
    input  logic               frame_active,
    output osd_pkg::buf_addr_t wr_addr,
    output logic [7:0]         wr_data,
    output logic               wr_en,
    output logic               osd_enable,
    output logic [31:0]        status,
    output logic [15:0]        joystick_0,
    output logic [15:0]        joystick_1
);

    import osd_pkg::*;

    decode_state_e state;
    // Target line and next column of a line write
    logic [3:0]    line_num;
    logic [4:0]    col_cnt;
    logic          is_line_cmd;

    assign is_line_cmd = (rx_data & CMD_LINE_WRITE_MASK) == CMD_LINE_WRITE_BASE;

    // ========================================
    // Command FSM
    // ========================================
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            line_num   <= 4'd0;
            col_cnt    <= 5'd0;
            wr_en      <= 1'b0;
            osd_enable <= 1'b0;
            status     <= 32'd0;
            joystick_0 <= 16'd0;
            joystick_1 <= 16'd0;
        end else begin
            // Single-cycle write strobe
            wr_en <= 1'b0;
            if (!frame_active) begin
                // Chip select high aborts any command in progress
                state <= ST_IDLE;
            end else if (rx_valid) begin
                case (state)
                    ST_IDLE: begin
                        if (is_line_cmd) begin
                            line_num <= rx_data[3:0];
                            col_cnt  <= 5'd0;
                            state    <= ST_LINE_DATA;
                        end else begin
                            case (osd_cmd_e'(rx_data))
                                CMD_OSD_DISABLE: osd_enable <= 1'b0;
                                CMD_OSD_ENABLE:  osd_enable <= 1'b1;
                                CMD_JOYSTICK_0:  state <= ST_JOY0_LO;
                                CMD_JOYSTICK_1:  state <= ST_JOY1_LO;
                                CMD_STATUS:      state <= ST_STATUS_0;
                                // Unknown opcodes are dropped
                                default:         state <= ST_IDLE;
                            endcase
                        end
                    end
                    ST_LINE_DATA: begin
                        wr_en   <= 1'b1;
                        col_cnt <= col_cnt + 5'd1;
                        // Last column ends the line
                        if (col_cnt == 5'(OSD_COLS - 1))
                            state <= ST_IDLE;
                    end
                    // Words fill low byte first
                    ST_JOY0_LO: begin
                        joystick_0[7:0] <= rx_data;
                        state           <= ST_JOY0_HI;
                    end
                    ST_JOY0_HI: begin
                        joystick_0[15:8] <= rx_data;
                        state            <= ST_IDLE;
                    end
                    ST_JOY1_LO: begin
                        joystick_1[7:0] <= rx_data;
                        state           <= ST_JOY1_HI;
                    end
                    ST_JOY1_HI: begin
                        joystick_1[15:8] <= rx_data;
                        state            <= ST_IDLE;
                    end
                    ST_STATUS_0: begin
                        status[7:0] <= rx_data;
                        state       <= ST_STATUS_1;
                    end
                    ST_STATUS_1: begin
                        status[15:8] <= rx_data;
                        state        <= ST_STATUS_2;
                    end
                    ST_STATUS_2: begin
                        status[23:16] <= rx_data;
                        state         <= ST_STATUS_3;
                    end
                    ST_STATUS_3: begin
                        status[31:24] <= rx_data;
                        state         <= ST_IDLE;
                    end
                    default: state <= ST_IDLE;
                endcase
            end
        end
    end

    // Write address and character, qualified by wr_en
    always_ff @(posedge clk_video) begin
        if (rx_valid && state == ST_LINE_DATA) begin
            wr_addr <= {line_num, col_cnt};
            wr_data <= rx_data;
        end
    end

endmodule

// File: verilog/spi_byte_rx.sv
// ========================================
// SPI mode-0 byte receiver
// Oversamples the SPI pins on clk_video,
// shifts MOSI in MSB first and strobes
// each completed byte for one cycle
// ========================================

module spi_byte_rx (
    input  logic       clk_video,
    input  logic       rst_n,
    input  logic       spi_clk,
    input  logic       spi_mosi,
    input  logic       spi_cs_n,
    output logic [7:0] rx_data,
    output logic       rx_valid,
    output logic       frame_active
);

    // Two-flop synchronizers, bit 1 is the usable copy
    logic [1:0] sclk_sync;
    logic [1:0] mosi_sync;
    logic [1:0] cs_sync;
    logic       sclk_prev;
    logic       sclk_rise;
    logic [2:0] bit_cnt;
    logic [6:0] shift_reg;

    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            sclk_sync <= 2'b00;
            mosi_sync <= 2'b00;
            cs_sync   <= 2'b11;
            sclk_prev <= 1'b0;
        end else begin
            sclk_sync <= {sclk_sync[0], spi_clk};
            mosi_sync <= {mosi_sync[0], spi_mosi};
            cs_sync   <= {cs_sync[0], spi_cs_n};
            sclk_prev <= sclk_sync[1];
        end
    end

    // Mode 0 samples on the rising edge
    assign sclk_rise    = sclk_sync[1] & ~sclk_prev;
    assign frame_active = ~cs_sync[1];

    // ========================================
    // Bit counter and byte strobe
    // ========================================
    always_ff @(posedge clk_video or negedge rst_n) begin
        if (!rst_n) begin
            bit_cnt  <= 3'd0;
            rx_valid <= 1'b0;
        end else begin
            rx_valid <= 1'b0;
            if (cs_sync[1]) begin
                // Deselected, restart at bit 7 of the next byte
                bit_cnt <= 3'd0;
            end else if (sclk_rise) begin
                bit_cnt <= bit_cnt + 3'd1;
                if (bit_cnt == 3'd7)
                    rx_valid <= 1'b1;
            end
        end
    end

    // Shift path, MSB arrives first
    always_ff @(posedge clk_video) begin
        if (sclk_rise && !cs_sync[1]) begin
            shift_reg <= {shift_reg[5:0], mosi_sync[1]};
            if (bit_cnt == 3'd7)
                rx_data <= {shift_reg, mosi_sync[1]};
        end
    end

endmodule

// File: verilog/osd_pkg.sv
// ========================================
// OSD shared definitions
// Command opcodes, decoder states, grid and
// window geometry, pixel types and colours
// ========================================

package osd_pkg;

    // ========================================
    // Command set
    // ========================================
    typedef enum logic [7:0] {
        CMD_JOYSTICK_0      = 8'h02,
        CMD_JOYSTICK_1      = 8'h03,
        CMD_STATUS          = 8'h1E,
        CMD_LINE_WRITE_BASE = 8'h20,
        CMD_OSD_DISABLE     = 8'h40,
        CMD_OSD_ENABLE      = 8'h41
    } osd_cmd_e;

    // Upper nibble identifies 0x20..0x2F line writes
    localparam logic [7:0] CMD_LINE_WRITE_MASK = 8'hF0;

    typedef enum logic [3:0] {
        ST_IDLE,
        ST_LINE_DATA,
        ST_JOY0_LO,
        ST_JOY0_HI,
        ST_JOY1_LO,
        ST_JOY1_HI,
        ST_STATUS_0,
        ST_STATUS_1,
        ST_STATUS_2,
        ST_STATUS_3
    } decode_state_e;

    // ========================================
    // Geometry
    // ========================================
    localparam int OSD_COLS = 32;
    localparam int OSD_ROWS = 16;
    localparam int CELL_PX  = 8;
    localparam int COORD_W  = 12;

    typedef logic [COORD_W-1:0] coord_t;
    // Line number in the upper 4 bits, column in the lower 5
    typedef logic [8:0]         buf_addr_t;
    typedef logic [23:0]        pixel_t;

    // Window origin, centred on a 1024x768 frame
    localparam coord_t OSD_X_OFFSET = 12'd384;
    localparam coord_t OSD_Y_OFFSET = 12'd320;

    // Yellow foreground
    localparam pixel_t OSD_FG_RGB = 24'hFFFF00;

endpackage
